/* logic/isaPkg.sv */
// Instruction set definitions
package isaPkg;

   //////////////////////////////////////////////////////////////////////
   // Data path sizes
   //////////////////////////////////////////////////////////////////////

   // Width of a data word and of an instruction
   localparam int wordWidth = 16;

   // Eight general registers
   localparam int regCount = 8;

   // Width of a register index
   localparam int regIdxWidth = 3;

   //////////////////////////////////////////////////////////////////////
   // Opcodes, instruction bits 15:11
   //////////////////////////////////////////////////////////////////////

   // Only the supported subset is listed
   // Any other encoding decodes as illegal
   typedef enum logic [4:0] {
      opNop   = 5'b00001,
      // Immediate ALU group
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      // Shift left by 8 and OR in the immediate
      opSlbi  = 5'b10010,
      // Shift immediate group
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      // Register ALU group, function in bits 1:0
      opAluR  = 5'b11011,
      // Signed comparisons
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110
   } opcodeT;

   //////////////////////////////////////////////////////////////////////
   // Operations performed by execute
   //////////////////////////////////////////////////////////////////////

   // A is the Rs value, B is the Rt value or the immediate
   typedef enum logic [3:0] {
      aluAdd,   // A + B
      aluSub,   // B - A
      aluXor,
      aluAndn,  // A and not B
      aluRol,
      aluSll,
      aluRor,
      aluSrl,
      aluPassB,
      aluSlbi,  // A shifted left 8, or B
      aluSeq,
      aluSlt,
      aluSle
   } aluOpT;

endpackage

/* logic/pipePkg.sv */
// Pipeline stage bundles
package pipePkg;

   import isaPkg::*;

   //////////////////////////////////////////////////////////////////////
   // Decode register contents
   //////////////////////////////////////////////////////////////////////

   // Registered at the end of decode, consumed by execute
   typedef struct packed {
      // An instruction is present this cycle
      logic                   valid;
      // Opcode outside the supported set
      logic                   illegal;
      // Result goes to the register file
      logic                   regWrite;
      logic [regIdxWidth-1:0] dest;
      aluOpT                  aluOp;
      // Rs value, already bypassed
      logic [wordWidth-1:0]   opA;
      // Rt value after bypass, or the extended immediate
      logic [wordWidth-1:0]   opB;
   } decodeBundleT;

   //////////////////////////////////////////////////////////////////////
   // Write-back report
   //////////////////////////////////////////////////////////////////////

   // Same layout for the live result and the registered report
   typedef struct packed {
      logic                   valid;
      logic                   illegal;
      logic                   regWrite;
      logic [regIdxWidth-1:0] dest;
      logic [wordWidth-1:0]   data;
   } writebackT;

endpackage

/* logic/regFile.sv */
// Eight entry register file
`timescale 1ns/10ps
`default_nettype none
module regFile
   import isaPkg::*;
(
   input  logic                   clk,
   input  logic                   rstN,
   // Read port A, Rs
   input  logic [regIdxWidth-1:0] readIdxA,
   // Read port B, Rt
   input  logic [regIdxWidth-1:0] readIdxB,
   // Single write port
   input  logic                   writeEn,
   input  logic [regIdxWidth-1:0] writeIdx,
   input  logic [wordWidth-1:0]   writeData,
   output logic [wordWidth-1:0]   readDataA,
   output logic [wordWidth-1:0]   readDataB
);

   // Register storage
   logic [wordWidth-1:0] regs [regCount];

   // All registers read zero after reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeIdx] <= writeData;
      end
   end

   // Plain asynchronous reads
   // A write in this cycle is not visible until the next one
   assign readDataA = regs[readIdxA];
   assign readDataB = regs[readIdxB];

endmodule
`default_nettype wire

/* logic/decodeStage.sv */
// Instruction decode stage
`timescale 1ns/10ps
`default_nettype none
module decodeStage
   import isaPkg::*, pipePkg::*;
(
   input  logic                 clk,
   input  logic                 rstN,
   // Single cycle strobe, no back-pressure
   input  logic                 instValid,
   input  logic [wordWidth-1:0] instruction,
   // Live result from execute, write port and bypass source
   input  writebackT            resultNow,
   output decodeBundleT         decodeOut
);

   opcodeT                 opcode;
   logic [regIdxWidth-1:0] rsIdx;
   logic [regIdxWidth-1:0] rtIdx;
   logic [wordWidth-1:0]   rsFile;
   logic [wordWidth-1:0]   rtFile;
   logic [wordWidth-1:0]   rsVal;
   logic [wordWidth-1:0]   rtVal;
   logic                   wbWrite;
   logic                   illegal;
   logic                   regWrite;
   logic                   useImm;
   logic [regIdxWidth-1:0] dest;
   aluOpT                  aluOp;
   logic [wordWidth-1:0]   imm;
   decodeBundleT           nextBundle;

   //////////////////////////////////////////////////////////////////////
   // Field extraction and register read
   //////////////////////////////////////////////////////////////////////

   assign opcode = opcodeT'(instruction[15:11]);
   assign rsIdx  = instruction[10:8];
   assign rtIdx  = instruction[7:5];

   // Execute writes straight into the file
   assign wbWrite = resultNow.valid & resultNow.regWrite;

   regFile i_regFile (
      .clk       (clk),
      .rstN      (rstN),
      .readIdxA  (rsIdx),
      .readIdxB  (rtIdx),
      .writeEn   (wbWrite),
      .writeIdx  (resultNow.dest),
      .writeData (resultNow.data),
      .readDataA (rsFile),
      .readDataB (rtFile)
   );

   // Back-to-back dependency
   // Take the value execute writes on this same edge
   assign rsVal = (wbWrite && resultNow.dest == rsIdx) ? resultNow.data : rsFile;
   assign rtVal = (wbWrite && resultNow.dest == rtIdx) ? resultNow.data : rtFile;

   //////////////////////////////////////////////////////////////////////
   // Opcode classification
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      // Immediate ALU and shift format by default
      illegal  = 1'b0;
      regWrite = 1'b1;
      useImm   = 1'b1;
      dest     = instruction[7:5];
      aluOp    = aluPassB;
      imm      = '0;
      case (opcode)
         opNop: begin
            regWrite = 1'b0;
         end
         // ADDI and SUBI sign-extend the 5-bit immediate
         opAddi: begin
            aluOp = aluAdd;
            imm   = {{(wordWidth-5){instruction[4]}}, instruction[4:0]};
         end
         opSubi: begin
            aluOp = aluSub;
            imm   = {{(wordWidth-5){instruction[4]}}, instruction[4:0]};
         end
         // Logic immediates are zero-extended
         opXori: begin
            aluOp = aluXor;
            imm   = {{(wordWidth-5){1'b0}}, instruction[4:0]};
         end
         opAndni: begin
            aluOp = aluAndn;
            imm   = {{(wordWidth-5){1'b0}}, instruction[4:0]};
         end
         // Shift amount is bits 3:0
         opRoli, opSlli, opRori, opSrli: begin
            aluOp = aluOpT'(aluRol + opcode[1:0]);
            imm   = {{(wordWidth-4){1'b0}}, instruction[3:0]};
         end
         // Rd is the Rs field, SLBI also reads it
         opSlbi: begin
            aluOp = aluSlbi;
            dest  = instruction[10:8];
            imm   = {{(wordWidth-8){1'b0}}, instruction[7:0]};
         end
         opLbi: begin
            dest  = instruction[10:8];
            imm   = {{(wordWidth-8){instruction[7]}}, instruction[7:0]};
         end
         // Three register format, Rd in bits 4:2
         opAluR: begin
            useImm = 1'b0;
            dest   = instruction[4:2];
            aluOp  = aluOpT'(aluAdd + instruction[1:0]);
         end
         opSeq, opSlt, opSle: begin
            useImm = 1'b0;
            dest   = instruction[4:2];
            aluOp  = aluOpT'(aluSeq + (opcode - opSeq));
         end
         default: begin
            illegal  = 1'b1;
            regWrite = 1'b0;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Decode register
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      nextBundle.valid    = instValid;
      nextBundle.illegal  = illegal;
      nextBundle.regWrite = regWrite;
      nextBundle.dest     = dest;
      nextBundle.aluOp    = aluOp;
      nextBundle.opA      = rsVal;
      nextBundle.opB      = useImm ? imm : rtVal;
   end

   // Loaded every cycle so valid lasts one cycle per strobe
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decodeOut <= '0;
      end else begin
         decodeOut <= nextBundle;
      end
   end

endmodule
`default_nettype wire

/* logic/executeStage.sv */
// Execute and write-back stage
`timescale 1ns/10ps
`default_nettype none
module executeStage
   import isaPkg::*, pipePkg::*;
(
   input  logic         clk,
   input  logic         rstN,
   input  decodeBundleT decodeIn,
   // Combinational, drives the register file write port
   output writebackT    resultNow,
   // Registered copy for the outside
   output writebackT    wbOut
);

   logic        [wordWidth-1:0]   opA;
   logic        [wordWidth-1:0]   opB;
   logic signed [wordWidth-1:0]   sA;
   logic signed [wordWidth-1:0]   sB;
   logic        [3:0]             shAmt;
   logic        [2*wordWidth-1:0] rolWide;
   logic        [2*wordWidth-1:0] rorWide;
   logic        [wordWidth-1:0]   result;

   assign opA = decodeIn.opA;
   assign opB = decodeIn.opB;
   assign sA  = decodeIn.opA;
   assign sB  = decodeIn.opB;

   // Only the low 4 bits of B count for shifts
   assign shAmt = opB[3:0];

   // Rotates through a doubled copy of A
   assign rolWide = {opA, opA} << shAmt;
   assign rorWide = {opA, opA} >> shAmt;

   //////////////////////////////////////////////////////////////////////
   // ALU, shifter and compare
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (decodeIn.aluOp)
         aluAdd:   result = opA + opB;
         // Subtract is reversed, B minus A
         aluSub:   result = opB - opA;
         aluXor:   result = opA ^ opB;
         aluAndn:  result = opA & ~opB;
         aluRol:   result = rolWide[2*wordWidth-1:wordWidth];
         aluSll:   result = opA << shAmt;
         aluRor:   result = rorWide[wordWidth-1:0];
         aluSrl:   result = opA >> shAmt;
         aluPassB: result = opB;
         aluSlbi:  result = {opA[wordWidth-9:0], 8'h00} | opB;
         // Compares give 1 or 0, signed
         aluSeq:   result = {{(wordWidth-1){1'b0}}, (opA == opB)};
         aluSlt:   result = {{(wordWidth-1){1'b0}}, (sA < sB)};
         aluSle:   result = {{(wordWidth-1){1'b0}}, (sA <= sB)};
         default:  result = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Write-back
   //////////////////////////////////////////////////////////////////////

   // Control fields pass straight through
   always_comb begin
      resultNow.valid    = decodeIn.valid;
      resultNow.illegal  = decodeIn.illegal;
      resultNow.regWrite = decodeIn.regWrite;
      resultNow.dest     = decodeIn.dest;
      resultNow.data     = result;
   end

   // Report lands on the same edge as the register write
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbOut <= '0;
      end else begin
         wbOut <= resultNow;
      end
   end

endmodule
`default_nettype wire

/* logic/coreTop.sv */
// Integer core slice top level
`timescale 1ns/10ps
`default_nettype none
module coreTop
   import isaPkg::*, pipePkg::*;
(
   input  logic                 clk,
   input  logic                 rstN,
   // One instruction per strobe, any cycle
   input  logic                 instValid,
   input  logic [wordWidth-1:0] instruction,
   // Report two cycles after the strobe
   output writebackT            wbOut
);

   //////////////////////////////////////////////////////////////////////
   // Stage connections
   //////////////////////////////////////////////////////////////////////

   // Decode register output
   decodeBundleT decodeOut;

   // Live result, write port and bypass
   writebackT    resultNow;

   decodeStage i_decodeStage (
      .clk         (clk),
      .rstN        (rstN),
      .instValid   (instValid),
      .instruction (instruction),
      .resultNow   (resultNow),
      .decodeOut   (decodeOut)
   );

   executeStage i_executeStage (
      .clk       (clk),
      .rstN      (rstN),
      .decodeIn  (decodeOut),
      .resultNow (resultNow),
      .wbOut     (wbOut)
   );

endmodule
`default_nettype wire

/* verification/coreTb.sv */
// Core slice testbench
`timescale 1ns/10ps
module coreTb
   import isaPkg::*, pipePkg::*;
();

   logic             clk;
   logic             rstN;
   logic             instValid;
   logic [15:0]      instruction;
   writebackT        wbOut;

   // Reference register state
   logic [15:0]      modelRegs [8];
   // Expected reports in issue order
   writebackT        expQ [$];
   // Strobes seen at the last two falling edges
   logic [1:0]       strobeHist;
   string            testName;
   int               waited;
   int               pick;
   logic [31:0]      rnd;
   logic [4:0]       op;
   logic [4:0]       legalOps [15];

   coreTop i_coreTop (
      .clk         (clk),
      .rstN        (rstN),
      .instValid   (instValid),
      .instruction (instruction),
      .wbOut       (wbOut)
   );

   // 4 ns period
   initial clk = 1'b0;
   always #2 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Failure handling and field compare
   //////////////////////////////////////////////////////////////////////

   task automatic stopRun();
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic checkField(input string field, input logic [15:0] expected,
                             input logic [15:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH test=%s field=%s expected=0x%04h actual=0x%04h",
                  testName, field, expected, actual);
         stopRun();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Applies one instruction to the model registers, returns its report
   function automatic writebackT modelStep(input logic [15:0] inst);
      writebackT   e;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] sImm5;
      logic [15:0] zImm5;
      logic [15:0] sImm8;
      logic [15:0] zImm8;
      logic [3:0]  sh;
      e          = '0;
      e.valid    = 1'b1;
      e.regWrite = 1'b1;
      a          = modelRegs[inst[10:8]];
      b          = modelRegs[inst[7:5]];
      sImm5      = {{11{inst[4]}}, inst[4:0]};
      zImm5      = {11'b0, inst[4:0]};
      sImm8      = {{8{inst[7]}}, inst[7:0]};
      zImm8      = {8'b0, inst[7:0]};
      sh         = inst[3:0];
      // Immediate and shift formats write bits 7:5
      e.dest     = inst[7:5];
      case (inst[15:11])
         5'b00001: e.regWrite = 1'b0;
         5'b01000: e.data = a + sImm5;
         // Immediate minus Rs
         5'b01001: e.data = sImm5 - a;
         5'b01010: e.data = a ^ zImm5;
         5'b01011: e.data = a & ~zImm5;
         5'b10010: begin
            e.dest = inst[10:8];
            e.data = {a[7:0], 8'h00} | zImm8;
         end
         5'b10100: e.data = (a << sh) | (a >> (16 - sh));
         5'b10101: e.data = a << sh;
         5'b10110: e.data = (a >> sh) | (a << (16 - sh));
         5'b10111: e.data = a >> sh;
         5'b11000: begin
            e.dest = inst[10:8];
            e.data = sImm8;
         end
         5'b11011: begin
            e.dest = inst[4:2];
            case (inst[1:0])
               2'b00: e.data = a + b;
               2'b01: e.data = b - a;
               2'b10: e.data = a ^ b;
               2'b11: e.data = a & ~b;
            endcase
         end
         5'b11100: begin
            e.dest = inst[4:2];
            e.data = {15'b0, a == b};
         end
         5'b11101: begin
            e.dest = inst[4:2];
            e.data = {15'b0, $signed(a) < $signed(b)};
         end
         5'b11110: begin
            e.dest = inst[4:2];
            e.data = {15'b0, $signed(a) <= $signed(b)};
         end
         default: begin
            e.illegal  = 1'b1;
            e.regWrite = 1'b0;
         end
      endcase
      if (e.regWrite) begin
         modelRegs[e.dest] = e.data;
      end
      return e;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Encoders and drivers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [15:0] immInst(input logic [4:0] opc, input logic [2:0] rs,
                                           input logic [2:0] rd, input logic [4:0] imm);
      return {opc, rs, rd, imm};
   endfunction

   function automatic logic [15:0] regInst(input logic [4:0] opc, input logic [2:0] rs,
                                           input logic [2:0] rt, input logic [2:0] rd,
                                           input logic [1:0] fn);
      return {opc, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] byteInst(input logic [4:0] opc, input logic [2:0] rd,
                                            input logic [7:0] imm);
      return {opc, rd, imm};
   endfunction

   // One clock of stimulus, model updated at the strobe
   task automatic driveCycle(input logic strobe, input logic [15:0] inst);
      @(posedge clk);
      instValid   <= strobe;
      instruction <= inst;
      if (strobe) begin
         expQ.push_back(modelStep(inst));
      end
   endtask

   task automatic sendInst(input logic [15:0] inst);
      driveCycle(1'b1, inst);
   endtask

   // Idle cycles carry junk on the instruction bus
   task automatic idleCycles(input int n);
      logic [31:0] junk;
      for (int i = 0; i < n; i++) begin
         junk = $urandom;
         driveCycle(1'b0, junk[15:0]);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Monitor, checks the report two cycles after each strobe
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin : monitor
      writebackT exp;
      if (rstN) begin
         checkField("valid", {15'b0, strobeHist[1]}, {15'b0, wbOut.valid});
         if (wbOut.valid) begin
            if (expQ.size() == 0) begin
               $display("Write-back report arrived with no instruction outstanding");
               stopRun();
            end else begin
               exp = expQ.pop_front();
               checkField("illegal", {15'b0, exp.illegal}, {15'b0, wbOut.illegal});
               checkField("regWrite", {15'b0, exp.regWrite}, {15'b0, wbOut.regWrite});
               // Dest and data only mean something for a write
               if (exp.regWrite) begin
                  checkField("dest", {13'b0, exp.dest}, {13'b0, wbOut.dest});
                  checkField("data", exp.data, wbOut.data);
               end
            end
         end
      end
      strobeHist = {strobeHist[0], instValid & rstN};
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(62000));
      rstN        = 1'b0;
      instValid   = 1'b0;
      instruction = '0;
      strobeHist  = '0;
      testName    = "reset";
      legalOps    = '{5'b00001, 5'b01000, 5'b01001, 5'b01010, 5'b01011,
                      5'b10010, 5'b10100, 5'b10101, 5'b10110, 5'b10111,
                      5'b11000, 5'b11011, 5'b11100, 5'b11101, 5'b11110};
      for (int i = 0; i < 8; i++) begin
         modelRegs[i] = '0;
      end
      repeat (10) @(posedge clk);
      rstN <= 1'b1;

      // Quiet bus, no reports expected
      testName = "resetIdle";
      idleCycles(20);
      testName = "resetZero";
      for (int i = 0; i < 8; i++) begin
         sendInst(immInst(opAddi, 3'(i), 3'(i), 5'd0));
      end
      idleCycles(3);

      // Gaps so operands come from the register file
      testName = "aluGroups";
      sendInst(byteInst(opLbi, 3'd1, 8'h85));
      sendInst(byteInst(opLbi, 3'd2, 8'h23));
      idleCycles(2);
      sendInst(immInst(opAddi, 3'd1, 3'd3, 5'b11101));
      sendInst(immInst(opSubi, 3'd2, 3'd4, 5'b10000));
      sendInst(immInst(opXori, 3'd1, 3'd5, 5'b10101));
      sendInst(immInst(opAndni, 3'd1, 3'd6, 5'b11111));
      idleCycles(2);
      sendInst(regInst(opAluR, 3'd1, 3'd2, 3'd7, 2'b00));
      sendInst(regInst(opAluR, 3'd1, 3'd2, 3'd7, 2'b01));
      sendInst(regInst(opAluR, 3'd1, 3'd2, 3'd7, 2'b10));
      sendInst(regInst(opAluR, 3'd1, 3'd2, 3'd7, 2'b11));
      idleCycles(3);

      testName = "byteShiftCompare";
      sendInst(byteInst(opSlbi, 3'd2, 8'hc4));
      idleCycles(2);
      sendInst(immInst(opRoli, 3'd2, 3'd3, 5'd5));
      sendInst(immInst(opSlli, 3'd2, 3'd4, 5'd12));
      sendInst(immInst(opRori, 3'd2, 3'd5, 5'd15));
      sendInst(immInst(opSrli, 3'd1, 3'd6, 5'd9));
      idleCycles(2);
      sendInst(regInst(opSeq, 3'd1, 3'd1, 3'd7, 2'b00));
      sendInst(regInst(opSlt, 3'd1, 3'd2, 3'd7, 2'b00));
      sendInst(regInst(opSle, 3'd2, 3'd1, 3'd7, 2'b00));
      sendInst(regInst(opSle, 3'd3, 3'd3, 3'd7, 2'b00));
      idleCycles(3);

      // Each one reads the previous destination next cycle
      testName = "backToBack";
      sendInst(byteInst(opLbi, 3'd1, 8'h05));
      sendInst(immInst(opAddi, 3'd1, 3'd2, 5'd3));
      sendInst(regInst(opAluR, 3'd1, 3'd2, 3'd3, 2'b01));
      sendInst(regInst(opAluR, 3'd3, 3'd2, 3'd1, 2'b10));
      sendInst(byteInst(opSlbi, 3'd1, 8'h7e));
      sendInst(immInst(opRoli, 3'd1, 3'd4, 5'd4));
      sendInst(regInst(opSlt, 3'd4, 3'd1, 3'd5, 2'b00));
      idleCycles(3);

      testName = "nopIllegal";
      sendInst({opNop, 11'h5a5});
      sendInst(immInst(5'b01100, 3'd2, 3'd6, 5'd7));
      sendInst(regInst(5'b11111, 3'd1, 3'd2, 3'd6, 2'b00));
      sendInst(immInst(opAddi, 3'd6, 3'd6, 5'd0));
      idleCycles(3);

      // Mostly legal opcodes, some fully random encodings
      testName = "randomMix";
      for (int n = 0; n < 2000; n++) begin
         rnd = $urandom;
         if (rnd[17:16] != 2'b00) begin
            pick = $urandom_range(0, 14);
            op   = legalOps[pick];
         end else begin
            op = rnd[15:11];
         end
         sendInst({op, rnd[10:0]});
         idleCycles($urandom_range(0, 3));
      end

      // Drain with a bounded wait
      waited = 0;
      while (expQ.size() != 0 && waited < 100) begin
         idleCycles(1);
         waited++;
      end
      idleCycles(6);
      if (expQ.size() != 0) begin
         $display("Write-back reports still missing after the drain timeout");
         stopRun();
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

/* all.f */
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/coreTop.sv
verification/coreTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = coreTb
FILELIST = all.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# A $fatal in the bench gives a non-zero exit status
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
